/* pcie_fc_init.f */
+incdir+source
source/dllp_pkg.sv
source/fc_init_pkg.sv
source/dllp_crc16.sv
source/dllp_rx_decode.sv
source/fc_init_fsm.sv
source/dllp_tx_framer.sv
source/pcie_fc_init_top.sv
verification/tb_pcie_fc_init.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the flow control init testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_pcie_fc_init \
  --Mdir obj_dir \
  -f pcie_fc_init.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_pcie_fc_init)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if grep -qxF '** PASS **' <<< "$sim_output"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

/* source/dllp_crc16.sv */
// DLLP CRC-16: combinational CRC over one 32-bit DLLP word
`timescale 1ns/1ps
`default_nettype none

module dllp_crc16 (
  input  logic [31:0] data_i,
  output logic [15:0] crc_o
);

  logic [15:0] crc_inv;

  always_comb begin : lfsr_calc
    logic [15:0] lfsr;
    logic        fb;
    lfsr = 16'hFFFF;
    fb   = 1'b0;
    // type byte first, each byte lsb first
    for (int b = 0; b < 4; b++) begin
      for (int j = 0; j < 8; j++) begin
        fb   = lfsr[15] ^ data_i[24 - 8 * b + j];
        lfsr = {lfsr[14:0], 1'b0} ^ (fb ? 16'h100B : 16'h0000);
      end
    end
    crc_inv = ~lfsr;
  end

  // reverse bits within each byte
  always_comb begin : byte_reverse
    for (int i = 0; i < 8; i++) begin
      crc_o[i]     = crc_inv[7 - i];
      crc_o[8 + i] = crc_inv[15 - i];
    end
  end

endmodule

`default_nettype wire

/* source/dllp_pkg.sv */
// DLLP package: type codes and the two views of a received or sent DLLP word
`default_nettype none

package dllp_pkg;

  // type byte of the DLLP, VC0 only
  typedef enum logic [7:0] {
    ACK          = 8'h00,
    NAK          = 8'h10,
    INITFC1_P    = 8'h40,
    INITFC1_NP   = 8'h50,
    INITFC1_CPL  = 8'h60,
    UPDATEFC_P   = 8'h80,
    UPDATEFC_NP  = 8'h90,
    UPDATEFC_CPL = 8'hA0,
    INITFC2_P    = 8'hC0,
    INITFC2_NP   = 8'hD0,
    INITFC2_CPL  = 8'hE0
  } dllp_type_e;

  // flow control DLLPs
  typedef struct packed {
    dllp_type_e  dllp_type;
    logic [1:0]  hdr_scale;
    logic [7:0]  hdr_fc;
    logic [1:0]  data_scale;
    logic [11:0] data_fc;
  } dllp_fc_t;

  // ack and nak DLLPs
  typedef struct packed {
    dllp_type_e  dllp_type;
    logic [11:0] reserved;
    logic [11:0] seq;
  } dllp_ack_t;

  typedef union packed {
    dllp_fc_t  fc;
    dllp_ack_t ack;
  } dllp_word_u;

endpackage

`default_nettype wire

/* source/dllp_rx_decode.sv */
// DLLP receive decoder: CRC check, partner credit capture and ack/nak report
`timescale 1ns/1ps
`default_nettype none

module dllp_rx_decode (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] rx_dllp_i,
  input  logic [15:0] rx_crc_i,
  input  logic        rx_valid_i,
  output logic        fc1_stored_o,
  output logic        fc2_seen_o,
  output logic [7:0]  p_hdr_o,
  output logic [7:0]  np_hdr_o,
  output logic [7:0]  cpl_hdr_o,
  output logic [11:0] p_data_o,
  output logic [11:0] np_data_o,
  output logic [11:0] cpl_data_o,
  output logic        ack_valid_o,
  output logic        nak_valid_o,
  output logic [11:0] ack_seq_o,
  output logic        crc_err_o
);

  dllp_pkg::dllp_word_u rx_word;
  logic [15:0]          crc_calc;
  logic                 good;
  logic                 is_fc2;
  logic                 is_ack;
  logic                 is_nak;
  logic [2:0]           class_hit;
  logic [2:0]           new_hit;
  logic [2:0]           latched_q;
  logic [2:0]           latched_next;

  dllp_crc16 crc_i (
    .data_i (rx_dllp_i),
    .crc_o  (crc_calc)
  );

  assign rx_word = rx_dllp_i;
  assign good    = rx_valid_i && (crc_calc == rx_crc_i);

  // InitFC1 and InitFC2 both carry initial credits
  always_comb begin
    case (rx_word.fc.dllp_type)
      dllp_pkg::INITFC1_P, dllp_pkg::INITFC2_P:     class_hit = 3'b001;
      dllp_pkg::INITFC1_NP, dllp_pkg::INITFC2_NP:   class_hit = 3'b010;
      dllp_pkg::INITFC1_CPL, dllp_pkg::INITFC2_CPL: class_hit = 3'b100;
      default:                                      class_hit = 3'b000;
    endcase
  end

  assign is_fc2 = rx_word.fc.dllp_type inside {
    dllp_pkg::INITFC2_P, dllp_pkg::INITFC2_NP, dllp_pkg::INITFC2_CPL,
    dllp_pkg::UPDATEFC_P, dllp_pkg::UPDATEFC_NP, dllp_pkg::UPDATEFC_CPL};
  assign is_ack = rx_word.ack.dllp_type == dllp_pkg::ACK;
  assign is_nak = rx_word.ack.dllp_type == dllp_pkg::NAK;

  // only the first DLLP of a class is taken
  assign new_hit      = class_hit & ~latched_q;
  assign latched_next = latched_q | new_hit;
  assign fc1_stored_o = &latched_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      latched_q   <= '0;
      fc2_seen_o  <= 1'b0;
      p_hdr_o     <= '0;
      np_hdr_o    <= '0;
      cpl_hdr_o   <= '0;
      p_data_o    <= '0;
      np_data_o   <= '0;
      cpl_data_o  <= '0;
      ack_valid_o <= 1'b0;
      nak_valid_o <= 1'b0;
      crc_err_o   <= 1'b0;
    end else begin
      ack_valid_o <= good && is_ack;
      nak_valid_o <= good && is_nak;
      crc_err_o   <= rx_valid_i && !good;
      if (good) begin
        latched_q <= latched_next;
        // partner has moved on to FC2
        if (is_fc2) begin
          fc2_seen_o <= 1'b1;
        end
        if (new_hit[0]) begin
          p_hdr_o  <= rx_word.fc.hdr_fc;
          p_data_o <= rx_word.fc.data_fc;
        end
        if (new_hit[1]) begin
          np_hdr_o  <= rx_word.fc.hdr_fc;
          np_data_o <= rx_word.fc.data_fc;
        end
        if (new_hit[2]) begin
          cpl_hdr_o  <= rx_word.fc.hdr_fc;
          cpl_data_o <= rx_word.fc.data_fc;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (good && (is_ack || is_nak)) begin
      ack_seq_o <= rx_word.ack.seq;
    end
  end

  fc2_after_fc1_a: assert property (
    @(posedge clk_i) disable iff (rst_i) fc2_seen_o |-> fc1_stored_o);

endmodule

`default_nettype wire

/* source/dllp_tx_framer.sv */
// DLLP transmit framer: builds InitFC word and CRC beat behind a skid register
`timescale 1ns/1ps
`default_nettype none

`include "pcie_fc_cfg.svh"

module dllp_tx_framer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  send_req_i,
  input  fc_init_pkg::fc_class_e send_class_i,
  input  logic                  fc2_phase_i,
  input  logic                  tx_tready_i,
  output logic                  framer_idle_o,
  output logic [31:0]           tx_tdata_o,
  output logic [3:0]            tx_tkeep_o,
  output logic                  tx_tvalid_o,
  output logic                  tx_tlast_o
);

  dllp_pkg::dllp_word_u word_c;
  logic [15:0]          crc_c;
  logic [15:0]          crc_q;
  logic                 busy_q;
  logic                 crc_pend_q;
  logic                 up_valid;
  logic                 up_ready;
  logic [31:0]          up_data;
  logic [3:0]           up_keep;
  logic                 up_last;
  logic                 skid_valid_q;
  logic [31:0]          skid_data_q;
  logic [3:0]           skid_keep_q;
  logic                 skid_last_q;

  always_comb begin
    word_c = '0;
    case (send_class_i)
      fc_init_pkg::FC_P:  word_c.fc.dllp_type = fc2_phase_i ? dllp_pkg::INITFC2_P
                                                            : dllp_pkg::INITFC1_P;
      fc_init_pkg::FC_NP: word_c.fc.dllp_type = fc2_phase_i ? dllp_pkg::INITFC2_NP
                                                            : dllp_pkg::INITFC1_NP;
      default:            word_c.fc.dllp_type = fc2_phase_i ? dllp_pkg::INITFC2_CPL
                                                            : dllp_pkg::INITFC1_CPL;
    endcase
    word_c.fc.hdr_fc  = 8'(`FC_HDR_CREDITS);
    // np data advertises the header count
    word_c.fc.data_fc = (send_class_i == fc_init_pkg::FC_NP) ? 12'(`FC_HDR_CREDITS)
                                                             : 12'(`FC_DATA_CREDITS);
  end

  dllp_crc16 crc_i (
    .data_i (word_c),
    .crc_o  (crc_c)
  );

  // beat source: word on the request, crc afterwards
  assign up_valid      = send_req_i || crc_pend_q;
  assign up_data       = crc_pend_q ? {16'h0000, crc_q} : word_c;
  assign up_keep       = crc_pend_q ? 4'h3 : 4'hF;
  assign up_last       = crc_pend_q;
  assign up_ready      = !skid_valid_q;
  assign framer_idle_o = !busy_q;

  always_ff @(posedge clk_i) begin
    if (send_req_i) begin
      crc_q <= crc_c;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      crc_pend_q   <= 1'b0;
      tx_tvalid_o  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (send_req_i) begin
        busy_q <= 1'b1;
      end else if (tx_tvalid_o && tx_tready_i && tx_tlast_o) begin
        busy_q <= 1'b0;
      end
      if (send_req_i) begin
        crc_pend_q <= 1'b1;
      end else if (crc_pend_q && up_ready) begin
        crc_pend_q <= 1'b0;
      end
      if (tx_tready_i || !tx_tvalid_o) begin
        tx_tvalid_o  <= skid_valid_q || up_valid;
        skid_valid_q <= 1'b0;
      end else if (up_valid && up_ready) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_tready_i || !tx_tvalid_o) begin
      if (skid_valid_q) begin
        tx_tdata_o <= skid_data_q;
        tx_tkeep_o <= skid_keep_q;
        tx_tlast_o <= skid_last_q;
      end else begin
        tx_tdata_o <= up_data;
        tx_tkeep_o <= up_keep;
        tx_tlast_o <= up_last;
      end
    end else if (up_ready) begin
      skid_data_q <= up_data;
      skid_keep_q <= up_keep;
      skid_last_q <= up_last;
    end
  end

  hold_under_stall_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    tx_tvalid_o && !tx_tready_i |=> tx_tvalid_o && $stable(tx_tdata_o) && $stable(tx_tlast_o));

endmodule

`default_nettype wire

/* source/fc_init_fsm.sv */
// Flow control init sequencer: sends InitFC1 then InitFC2 triplets with retries
`timescale 1ns/1ps
`default_nettype none

`include "pcie_fc_cfg.svh"

module fc_init_fsm (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  link_up_i,
  input  logic                  fc1_stored_i,
  input  logic                  fc2_seen_i,
  input  logic                  framer_idle_i,
  output logic                  send_req_o,
  output fc_init_pkg::fc_class_e send_class_o,
  output logic                  fc2_phase_o,
  output logic                  fc_init_done_o
);

  localparam int CntW = $clog2(`FC_WAIT_CYCLES + 1);
  localparam logic [CntW-1:0] CntLast = CntW'(`FC_WAIT_CYCLES - 1);

  fc_init_pkg::fc_state_e state_q;
  fc_init_pkg::fc_class_e class_q;
  logic                   fc2_phase_q;
  logic [CntW-1:0]        cnt_q;
  logic                   cnt_end;

  assign cnt_end        = cnt_q == CntLast;
  assign send_req_o     = state_q == fc_init_pkg::ST_ISSUE;
  assign send_class_o   = class_q;
  assign fc2_phase_o    = fc2_phase_q;
  assign fc_init_done_o = state_q == fc_init_pkg::ST_DONE;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= fc_init_pkg::ST_IDLE;
      class_q     <= fc_init_pkg::FC_P;
      fc2_phase_q <= 1'b0;
      cnt_q       <= '0;
    end else if (!link_up_i) begin
      state_q <= fc_init_pkg::ST_IDLE;
    end else begin
      case (state_q)
        fc_init_pkg::ST_IDLE: begin
          class_q     <= fc_init_pkg::FC_P;
          fc2_phase_q <= 1'b0;
          state_q     <= fc_init_pkg::ST_SEND;
        end
        fc_init_pkg::ST_SEND: begin
          if (framer_idle_i) begin
            state_q <= fc_init_pkg::ST_ISSUE;
          end
        end
        // framer takes the request here, idle drops next cycle
        fc_init_pkg::ST_ISSUE: begin
          state_q <= fc_init_pkg::ST_BUSY;
        end
        fc_init_pkg::ST_BUSY: begin
          if (framer_idle_i) begin
            cnt_q <= '0;
            if (class_q == fc_init_pkg::FC_CPL) begin
              state_q <= fc_init_pkg::ST_CHECK;
            end else begin
              class_q <= (class_q == fc_init_pkg::FC_P) ? fc_init_pkg::FC_NP
                                                        : fc_init_pkg::FC_CPL;
              state_q <= fc_init_pkg::ST_GAP;
            end
          end
        end
        fc_init_pkg::ST_GAP: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_end) begin
            state_q <= fc_init_pkg::ST_SEND;
          end
        end
        // triplet sent, wait for the partner or retry
        fc_init_pkg::ST_CHECK: begin
          cnt_q <= cnt_q + 1'b1;
          if (!fc2_phase_q && fc1_stored_i) begin
            fc2_phase_q <= 1'b1;
            class_q     <= fc_init_pkg::FC_P;
            cnt_q       <= '0;
            state_q     <= fc_init_pkg::ST_GAP;
          end else if (fc2_phase_q && fc2_seen_i) begin
            state_q <= fc_init_pkg::ST_DONE;
          end else if (cnt_end) begin
            class_q <= fc_init_pkg::FC_P;
            state_q <= fc_init_pkg::ST_SEND;
          end
        end
        fc_init_pkg::ST_DONE: begin
          state_q <= fc_init_pkg::ST_DONE;
        end
        default: begin
          state_q <= fc_init_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // framer must still be idle when it sees the request
  req_when_idle_a: assert property (
    @(posedge clk_i) disable iff (rst_i) send_req_o |-> framer_idle_i);

endmodule

`default_nettype wire

/* source/fc_init_pkg.sv */
// Flow control init package: credit classes and init sequencer states
`default_nettype none

package fc_init_pkg;

  typedef enum logic [1:0] {
    FC_P   = 2'd0,
    FC_NP  = 2'd1,
    FC_CPL = 2'd2
  } fc_class_e;

  typedef enum logic [3:0] {
    ST_IDLE  = 4'd0,
    ST_SEND  = 4'd1,
    ST_ISSUE = 4'd2,
    ST_BUSY  = 4'd3,
    ST_GAP   = 4'd4,
    ST_CHECK = 4'd5,
    ST_DONE  = 4'd6
  } fc_state_e;

endpackage

`default_nettype wire

/* source/pcie_fc_cfg.svh */
// Flow control init configuration: DLLP spacing and advertised credit counts
`ifndef PCIE_FC_CFG_SVH
`define PCIE_FC_CFG_SVH

// cycles between DLLPs and before a retry
`define FC_WAIT_CYCLES 160

// advertised header credits
`define FC_HDR_CREDITS 32

// max payload 256 bytes in 16 byte units
`define FC_DATA_CREDITS 16

`endif

/* source/pcie_fc_init_top.sv */
// PCIe flow control init top: receive decoder, init sequencer and DLLP framer
`timescale 1ns/1ps
`default_nettype none

module pcie_fc_init_top (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        link_up_i,
  input  logic [31:0] rx_dllp_i,
  input  logic [15:0] rx_crc_i,
  input  logic        rx_valid_i,
  input  logic        tx_tready_i,
  output logic [31:0] tx_tdata_o,
  output logic [3:0]  tx_tkeep_o,
  output logic        tx_tvalid_o,
  output logic        tx_tlast_o,
  output logic [7:0]  p_hdr_o,
  output logic [7:0]  np_hdr_o,
  output logic [7:0]  cpl_hdr_o,
  output logic [11:0] p_data_o,
  output logic [11:0] np_data_o,
  output logic [11:0] cpl_data_o,
  output logic        ack_valid_o,
  output logic        nak_valid_o,
  output logic [11:0] ack_seq_o,
  output logic        crc_err_o,
  output logic        fc_init_done_o
);

  logic                   fc1_stored;
  logic                   fc2_seen;
  logic                   send_req;
  fc_init_pkg::fc_class_e send_class;
  logic                   fc2_phase;
  logic                   framer_idle;

  dllp_rx_decode rx_decode_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_dllp_i    (rx_dllp_i),
    .rx_crc_i     (rx_crc_i),
    .rx_valid_i   (rx_valid_i),
    .fc1_stored_o (fc1_stored),
    .fc2_seen_o   (fc2_seen),
    .p_hdr_o      (p_hdr_o),
    .np_hdr_o     (np_hdr_o),
    .cpl_hdr_o    (cpl_hdr_o),
    .p_data_o     (p_data_o),
    .np_data_o    (np_data_o),
    .cpl_data_o   (cpl_data_o),
    .ack_valid_o  (ack_valid_o),
    .nak_valid_o  (nak_valid_o),
    .ack_seq_o    (ack_seq_o),
    .crc_err_o    (crc_err_o)
  );

  fc_init_fsm fsm_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .link_up_i      (link_up_i),
    .fc1_stored_i   (fc1_stored),
    .fc2_seen_i     (fc2_seen),
    .framer_idle_i  (framer_idle),
    .send_req_o     (send_req),
    .send_class_o   (send_class),
    .fc2_phase_o    (fc2_phase),
    .fc_init_done_o (fc_init_done_o)
  );

  dllp_tx_framer framer_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .send_req_i    (send_req),
    .send_class_i  (send_class),
    .fc2_phase_i   (fc2_phase),
    .tx_tready_i   (tx_tready_i),
    .framer_idle_o (framer_idle),
    .tx_tdata_o    (tx_tdata_o),
    .tx_tkeep_o    (tx_tkeep_o),
    .tx_tvalid_o   (tx_tvalid_o),
    .tx_tlast_o    (tx_tlast_o)
  );

endmodule

`default_nettype wire

/* verification/tb_pcie_fc_init.sv */
// Testbench for the PCIe flow control init block: directed tests and a tx stream model
`timescale 1ns/1ps
`default_nettype none

`include "pcie_fc_cfg.svh"

module tb_pcie_fc_init;

  localparam int WaitLimit = 1000;
  localparam int DoneLimit = 2000;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        link_up_i;
  logic [31:0] rx_dllp_i;
  logic [15:0] rx_crc_i;
  logic        rx_valid_i;
  logic        tx_tready_i = 1'b0;
  logic [31:0] tx_tdata_o;
  logic [3:0]  tx_tkeep_o;
  logic        tx_tvalid_o;
  logic        tx_tlast_o;
  logic [7:0]  p_hdr_o;
  logic [7:0]  np_hdr_o;
  logic [7:0]  cpl_hdr_o;
  logic [11:0] p_data_o;
  logic [11:0] np_data_o;
  logic [11:0] cpl_data_o;
  logic        ack_valid_o;
  logic        nak_valid_o;
  logic [11:0] ack_seq_o;
  logic        crc_err_o;
  logic        fc_init_done_o;

  // beats seen on the tx stream by the monitor
  logic [31:0] beat_data [256];
  logic [3:0]  beat_keep [256];
  logic        beat_last [256];
  int          beat_total = 0;
  int          stall_errors = 0;
  logic        stall_q = 1'b0;
  logic [31:0] stall_data_q;
  logic        stall_last_q;
  logic [31:0] rng_q = 32'd6;

  // expected stream state and error counts
  int          taken_beats = 0;
  logic [1:0]  exp_class = 2'd0;
  logic        exp_fc2 = 1'b0;
  logic        fc1_given = 1'b0;
  int          given_beat = 0;
  int          fc1_late = 0;
  int          fc2_taken = 0;
  logic [7:0]  exp_hdr [3] = '{default: '0};
  logic [11:0] exp_data [3] = '{default: '0};
  int          checks = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          timeouts = 0;

  pcie_fc_init_top dut_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .link_up_i      (link_up_i),
    .rx_dllp_i      (rx_dllp_i),
    .rx_crc_i       (rx_crc_i),
    .rx_valid_i     (rx_valid_i),
    .tx_tready_i    (tx_tready_i),
    .tx_tdata_o     (tx_tdata_o),
    .tx_tkeep_o     (tx_tkeep_o),
    .tx_tvalid_o    (tx_tvalid_o),
    .tx_tlast_o     (tx_tlast_o),
    .p_hdr_o        (p_hdr_o),
    .np_hdr_o       (np_hdr_o),
    .cpl_hdr_o      (cpl_hdr_o),
    .p_data_o       (p_data_o),
    .np_data_o      (np_data_o),
    .cpl_data_o     (cpl_data_o),
    .ack_valid_o    (ack_valid_o),
    .nak_valid_o    (nak_valid_o),
    .ack_seq_o      (ack_seq_o),
    .crc_err_o      (crc_err_o),
    .fc_init_done_o (fc_init_done_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ready is high about three cycles in four
  always @(negedge clk_i) begin
    rng_q = xorshift(rng_q);
    tx_tready_i = rng_q[1:0] != 2'b00;
  end

  always @(posedge clk_i) begin : tx_monitor
    if (stall_q && (!tx_tvalid_o || tx_tdata_o !== stall_data_q ||
                    tx_tlast_o !== stall_last_q)) begin
      stall_errors++;
      $display("FAIL tx_tdata_o under back-pressure: got %h expected %h", tx_tdata_o,
               stall_data_q);
    end
    stall_q      = !rst_i && tx_tvalid_o && !tx_tready_i;
    stall_data_q = tx_tdata_o;
    stall_last_q = tx_tlast_o;
    if (!rst_i && tx_tvalid_o && tx_tready_i) begin
      beat_data[8'(beat_total)] = tx_tdata_o;
      beat_keep[8'(beat_total)] = tx_tkeep_o;
      beat_last[8'(beat_total)] = tx_tlast_o;
      beat_total++;
    end
  end

  // poly 100Bh, type byte first, each byte lsb first, inverted, bits of each byte reversed
  function automatic logic [15:0] ref_crc(input logic [31:0] word);
    logic [15:0] lfsr;
    logic [7:0]  byte_v;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  rlo;
    logic [7:0]  rhi;
    logic        fb;
    lfsr = 16'hFFFF;
    rlo  = 8'h00;
    rhi  = 8'h00;
    for (int b = 0; b < 4; b++) begin
      byte_v = 8'(word >> (24 - 8 * b));
      for (int j = 0; j < 8; j++) begin
        fb     = byte_v[0] ^ lfsr[15];
        byte_v = byte_v >> 1;
        lfsr   = {lfsr[14:0], 1'b0} ^ (fb ? 16'h100B : 16'h0000);
      end
    end
    lo = ~lfsr[7:0];
    hi = ~lfsr[15:8];
    for (int i = 0; i < 8; i++) begin
      rlo = {rlo[6:0], lo[0]};
      rhi = {rhi[6:0], hi[0]};
      lo  = lo >> 1;
      hi  = hi >> 1;
    end
    return {rhi, rlo};
  endfunction

  function automatic dllp_pkg::dllp_word_u make_fc_word(input dllp_pkg::dllp_type_e t,
                                                       input logic [7:0] hdr,
                                                       input logic [11:0] data);
    dllp_pkg::dllp_word_u w;
    w = '0;
    w.fc.dllp_type = t;
    w.fc.hdr_fc    = hdr;
    w.fc.data_fc   = data;
    return w;
  endfunction

  function automatic dllp_pkg::dllp_word_u make_ack_word(input dllp_pkg::dllp_type_e t,
                                                        input logic [11:0] seq);
    dllp_pkg::dllp_word_u w;
    w = '0;
    w.ack.dllp_type = t;
    w.ack.seq       = seq;
    return w;
  endfunction

  function automatic dllp_pkg::dllp_type_e init_type(input logic [1:0] cls, input logic fc2);
    case (cls)
      2'd0:    return fc2 ? dllp_pkg::INITFC2_P : dllp_pkg::INITFC1_P;
      2'd1:    return fc2 ? dllp_pkg::INITFC2_NP : dllp_pkg::INITFC1_NP;
      default: return fc2 ? dllp_pkg::INITFC2_CPL : dllp_pkg::INITFC1_CPL;
    endcase
  endfunction

  task automatic end_run();
    $display("checks %0d, value errors %0d, stall errors %0d, other errors %0d, timeouts %0d",
             checks, value_errors, stall_errors, other_errors, timeouts);
    if (value_errors == 0 && stall_errors == 0 && other_errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dllp(input dllp_pkg::dllp_word_u got, input dllp_pkg::dllp_type_e exp_type,
                            input logic [7:0] exp_hdr_v, input logic [11:0] exp_data_v);
    dllp_pkg::dllp_word_u exp_word;
    exp_word = make_fc_word(exp_type, exp_hdr_v, exp_data_v);
    checks++;
    if (got !== exp_word) begin
      value_errors++;
      $display("FAIL tx_tdata_o: got %h expected %h", got, exp_word);
    end
  endtask

  task automatic check_crc(input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL tx_tdata_o crc: got %h expected %h", got, exp);
    end
  endtask

  task automatic credit_field(input string name, input logic [11:0] got, input logic [11:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_credits();
    credit_field("p_hdr_o", 12'(p_hdr_o), 12'(exp_hdr[0]));
    credit_field("np_hdr_o", 12'(np_hdr_o), 12'(exp_hdr[1]));
    credit_field("cpl_hdr_o", 12'(cpl_hdr_o), 12'(exp_hdr[2]));
    credit_field("p_data_o", p_data_o, exp_data[0]);
    credit_field("np_data_o", np_data_o, exp_data[1]);
    credit_field("cpl_data_o", cpl_data_o, exp_data[2]);
  endtask

  task automatic check_ack(input logic exp_ack, input logic exp_nak, input logic [11:0] exp_seq);
    check_value("ack_valid_o", 32'(ack_valid_o), 32'(exp_ack));
    check_value("nak_valid_o", 32'(nak_valid_o), 32'(exp_nak));
    if (exp_ack || exp_nak) begin
      check_value("ack_seq_o", 32'(ack_seq_o), 32'(exp_seq));
    end
  endtask

  // one cycle strobe with results visible on return
  task automatic send_rx(input logic [31:0] word, input logic [15:0] crc);
    @(negedge clk_i);
    rx_dllp_i  = word;
    rx_crc_i   = crc;
    rx_valid_i = 1'b1;
    @(negedge clk_i);
    rx_valid_i = 1'b0;
  endtask

  // pops the next word and crc beat and checks them against the model
  task automatic take_dllp();
    int                   waited;
    dllp_pkg::dllp_word_u got_word;
    dllp_pkg::dllp_type_e exp_type;
    logic [7:0]           hdr;
    logic [11:0]          data;
    waited = 0;
    while (beat_total - taken_beats < 2 && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (beat_total - taken_beats < 2) begin
      $display("timeout: no complete DLLP on the tx stream within %0d cycles", WaitLimit);
      timeouts++;
    end else begin
      got_word = beat_data[8'(taken_beats)];
      // phase changes only at the start of a triplet
      if (exp_class == 2'd0 && fc1_given && taken_beats >= given_beat &&
          got_word.fc.dllp_type == dllp_pkg::INITFC2_P) begin
        exp_fc2 = 1'b1;
      end
      exp_type = init_type(exp_class, exp_fc2);
      hdr      = 8'(`FC_HDR_CREDITS);
      data     = (exp_class == 2'd1) ? 12'(`FC_HDR_CREDITS) : 12'(`FC_DATA_CREDITS);
      check_dllp(got_word, exp_type, hdr, data);
      check_value("tx_tkeep_o", 32'(beat_keep[8'(taken_beats)]), 32'hF);
      check_value("tx_tlast_o", 32'(beat_last[8'(taken_beats)]), 32'h0);
      if (exp_fc2) begin
        fc2_taken++;
      end else if (fc1_given && taken_beats >= given_beat) begin
        fc1_late++;
      end
      taken_beats++;
      check_crc(beat_data[8'(taken_beats)][15:0], ref_crc(make_fc_word(exp_type, hdr, data)));
      check_value("tx_tdata_o[31:16]", 32'(beat_data[8'(taken_beats)][31:16]), 32'h0);
      check_value("tx_tkeep_o", 32'(beat_keep[8'(taken_beats)]), 32'h3);
      check_value("tx_tlast_o", 32'(beat_last[8'(taken_beats)]), 32'h1);
      taken_beats++;
      exp_class = (exp_class == 2'd2) ? 2'd0 : exp_class + 2'd1;
    end
  endtask

  task automatic give_credits(input logic [1:0] cls, input logic [7:0] hdr,
                              input logic [11:0] data);
    dllp_pkg::dllp_word_u word;
    word = make_fc_word(init_type(cls, 1'b0), hdr, data);
    send_rx(word, ref_crc(word));
    exp_hdr[cls]  = hdr;
    exp_data[cls] = data;
    check_credits();
    check_value("crc_err_o", 32'(crc_err_o), 32'd0);
  endtask

  task automatic check_reset_state();
    check_value("tx_tvalid_o", 32'(tx_tvalid_o), 32'd0);
    check_value("fc_init_done_o", 32'(fc_init_done_o), 32'd0);
    check_value("crc_err_o", 32'(crc_err_o), 32'd0);
    check_ack(1'b0, 1'b0, 12'h000);
    check_credits();
  endtask

  task automatic stream_fc1_triplets();
    @(negedge clk_i);
    link_up_i = 1'b1;
    // nothing received so the FC1 triplet repeats
    repeat (6) take_dllp();
    check_value("fc_init_done_o", 32'(fc_init_done_o), 32'd0);
  endtask

  task automatic reject_bad_crc();
    dllp_pkg::dllp_word_u word;
    word = make_fc_word(dllp_pkg::INITFC1_P, 8'h11, 12'h222);
    send_rx(word, ref_crc(word) ^ 16'h0100);
    check_value("crc_err_o", 32'(crc_err_o), 32'd1);
    check_credits();
    @(negedge clk_i);
    check_value("crc_err_o", 32'(crc_err_o), 32'd0);
    check_credits();
  endtask

  task automatic report_ack_nak();
    dllp_pkg::dllp_word_u word;
    word = make_ack_word(dllp_pkg::ACK, 12'h5A3);
    send_rx(word, ref_crc(word));
    check_ack(1'b1, 1'b0, 12'h5A3);
    check_value("crc_err_o", 32'(crc_err_o), 32'd0);
    word = make_ack_word(dllp_pkg::NAK, 12'h0C7);
    send_rx(word, ref_crc(word));
    check_ack(1'b0, 1'b1, 12'h0C7);
    @(negedge clk_i);
    check_ack(1'b0, 1'b0, 12'h000);
    check_credits();
  endtask

  task automatic store_partner_credits();
    give_credits(2'd0, 8'h1C, 12'h0A0);
    give_credits(2'd1, 8'h0E, 12'h01C);
    give_credits(2'd2, 8'h40, 12'h300);
    fc1_given  = 1'b1;
    given_beat = beat_total;
    for (int n = 0; n < 9 && fc2_taken < 3; n++) begin
      take_dllp();
    end
    if (fc2_taken < 3) begin
      other_errors++;
      $display("no InitFC2 triplet was sent after the partner credits were stored");
    end
    if (fc1_late > 3) begin
      other_errors++;
      $display("InitFC1 was sent %0d times after the partner credits were stored", fc1_late);
    end
    check_value("fc_init_done_o", 32'(fc_init_done_o), 32'd0);
  endtask

  task automatic finish_fc2_handshake();
    dllp_pkg::dllp_word_u word;
    int                   waited;
    word = make_fc_word(dllp_pkg::INITFC2_P, 8'h55, 12'h555);
    send_rx(word, ref_crc(word));
    // credits were taken from InitFC1 already
    check_credits();
    waited = 0;
    while (fc_init_done_o !== 1'b1 && waited < DoneLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (fc_init_done_o !== 1'b1) begin
      $display("timeout: fc_init_done_o did not rise within %0d cycles", DoneLimit);
      timeouts++;
    end else begin
      while (beat_total - taken_beats >= 2) begin
        take_dllp();
      end
      if (beat_total != taken_beats || exp_class != 2'd0) begin
        other_errors++;
        $display("tx stream stopped inside a DLLP or a triplet");
      end
      for (int n = 0; n < 2 * `FC_WAIT_CYCLES; n++) begin
        @(negedge clk_i);
      end
      if (beat_total != taken_beats) begin
        other_errors++;
        $display("tx stream kept sending after init was done");
      end
      check_value("fc_init_done_o", 32'(fc_init_done_o), 32'd1);
      check_value("tx_tvalid_o", 32'(tx_tvalid_o), 32'd0);
    end
  endtask

  initial begin : run
    rst_i      = 1'b1;
    link_up_i  = 1'b0;
    rx_dllp_i  = 32'h0;
    rx_crc_i   = 16'h0;
    rx_valid_i = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;
    check_reset_state();
    stream_fc1_triplets();
    reject_bad_crc();
    report_ack_nak();
    store_partner_credits();
    finish_fc2_handshake();
    end_run();
  end

endmodule

`default_nettype wire
